//--- atm_mapper.f
+incdir+sim
verilog/z80_bus_pkg.sv
verilog/memmap_pkg.sv
verilog/bus_cycle_latch.sv
verilog/z80_bus_front.sv
verilog/window_pagers.sv
verilog/dos_control.sv
verilog/mem_translate.sv
verilog/atm_mapper_top.sv
sim/tb_atm_mapper.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_atm_mapper \
	-f atm_mapper.f

output=$(./obj_dir/Vtb_atm_mapper 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi

//--- sim/mapper_model.svh
`ifndef MAPPER_MODEL_SVH
`define MAPPER_MODEL_SVH

// expected pager state as written by the z80
window_map_t ref_pages [NUM_WINDOWS];
logic        ref_pager_on;
logic        ref_dos;

// fixed map while the pager is off: rom 0, ram 5, ram 2, ram 0
function automatic window_map_t fixed_window(input logic [1:0] win);
	window_map_t w;
	w.rom = (win == 2'd0);
	case (win)
		2'd1: w.page = 8'd5;
		2'd2: w.page = 8'd2;
		default: w.page = 8'd0;
	endcase
	return w;
endfunction

function automatic void reset_model();
	for (int i = 0; i < NUM_WINDOWS; i++)
		ref_pages[i] = fixed_window(2'(i));
	ref_pager_on = 1'b0;
	ref_dos = 1'b0;
endfunction

// out to the pager port picks the window by a15..a14, d7 high means ram
function automatic void apply_io_write(input logic [15:0] port_addr, input logic [7:0] data);
	if (port_addr[7:0] == PAGER_PORT_DEFAULT)
	begin
		ref_pages[port_addr[15:14]].rom = ~data[7];
		ref_pages[port_addr[15:14]].page = {1'b0, data[6:0]};
	end
	else if (port_addr[7:0] == CONFIG_PORT_DEFAULT)
		ref_pager_on = data[0];
endfunction

function automatic window_map_t window_in_use(input logic [1:0] win);
	if (ref_pager_on)
		return ref_pages[win];
	return fixed_window(win);
endfunction

// translation uses the dos flag from before this cycle
function automatic mem_access_t predict_access(input logic [15:0] addr, input logic wr,
	input logic m1);
	window_map_t w;
	window_map_t w0;
	mem_access_t acc;
	w = window_in_use(addr[15:14]);
	w0 = window_in_use(2'd0);
	acc.rom = w.rom;
	acc.page = w.page;
	acc.offset = addr[13:0];
	acc.wr = wr;
	if (w.rom)
		acc.page = {3'b000, w.page[4:1], ref_dos};
	if (m1 && (addr[15:8] == DOS_ENTRY_DEFAULT) && w0.rom)
		ref_dos = 1'b1;
	else if (m1 && (addr[15:14] != 2'b00))
		ref_dos = 1'b0;
	return acc;
endfunction

`endif

//--- sim/tb_atm_mapper.sv
`timescale 1ns/100ps

module tb_atm_mapper;

	import z80_bus_pkg::*;
	import memmap_pkg::*;

	`include "mapper_model.svh"

	localparam int NUM_RANDOM = 400;
	localparam int MAX_CYCLES = NUM_RANDOM * 12 + 100;

	logic        fclk;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  d;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic        mem_valid;
	mem_access_t mem_access;
	logic        dos;

	// expected result of the memory cycle in flight
	mem_access_t exp_access;
	logic        exp_dos;
	string       exp_name;
	int          issued_count = 0;
	int          valid_count = 0;
	int          cycle_count = 0;

	atm_mapper_top UUT (
		.fclk      (fclk),
		.rst       (rst),
		.a         (a),
		.d         (d),
		.iorq_n    (iorq_n),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.mem_valid (mem_valid),
		.mem_access(mem_access),
		.dos       (dos)
	);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_access(input string name, input mem_access_t exp,
		input mem_access_t act);
		if (act !== exp)
		begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_dos(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("Error: %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	always @(posedge fclk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			stop_with_error("timeout, the run went past its cycle limit");
	end

	// results sampled mid-cycle away from the clock edge
	always @(negedge fclk)
	begin
		if (!rst && mem_valid)
		begin
			if (valid_count >= issued_count)
				stop_with_error("mem_valid came without a memory cycle to answer");
			else
			begin
				check_access(exp_name, exp_access, mem_access);
				check_dos({exp_name, "_dos"}, exp_dos, dos);
				valid_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_step();
		@(posedge fclk);
		#2;
	endtask

	task automatic bus_idle();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
	endtask

	task automatic io_write(input logic [15:0] port_addr, input logic [7:0] data);
		apply_io_write(port_addr, data);
		a = port_addr;
		d = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		repeat (6) bus_step();
		bus_idle();
		repeat (3) bus_step();
	endtask

	task automatic io_read(input logic [15:0] port_addr);
		a = port_addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		repeat (6) bus_step();
		bus_idle();
		repeat (3) bus_step();
	endtask

	task automatic mem_cycle(input string name, input logic [15:0] addr, input logic wr,
		input logic m1);
		int waited;
		exp_access = predict_access(addr, wr, m1);
		exp_dos = ref_dos;
		exp_name = name;
		issued_count++;
		a = addr;
		d = 8'($urandom);
		m1_n = ~m1;
		mreq_n = 1'b0;
		rd_n = wr;
		wr_n = ~wr;
		repeat (6) bus_step();
		bus_idle();
		waited = 6;
		while (valid_count != issued_count && waited < 10)
		begin
			bus_step();
			waited++;
		end
		if (valid_count != issued_count)
			stop_with_error({name, ": no mem_valid within 10 cycles"});
		repeat (3) bus_step();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int unsigned r;
		logic [7:0] port;
		void'($urandom(58));
		rst = 1'b1;
		a = '0;
		d = '0;
		bus_idle();
		reset_model();
		repeat (8) @(posedge fclk);
		#2;
		rst = 1'b0;

		// fixed map straight out of reset
		for (int w = 0; w < NUM_WINDOWS; w++)
		begin
			mem_cycle("reset_read", {2'(w), 14'($urandom)}, 1'b0, 1'b0);
			mem_cycle("reset_write", {2'(w), 14'($urandom)}, 1'b1, 1'b0);
		end

		// pages stored while off apply once enabled
		io_write({8'h40, PAGER_PORT_DEFAULT}, 8'h83);
		io_write({8'h00, PAGER_PORT_DEFAULT}, 8'h06);
		mem_cycle("pager_off", 16'h4321, 1'b0, 1'b0);
		mem_cycle("pager_off", 16'h0321, 1'b0, 1'b0);
		io_write({8'h00, CONFIG_PORT_DEFAULT}, 8'h01);
		mem_cycle("pager_on", 16'h4321, 1'b1, 1'b0);
		mem_cycle("pager_on", 16'h0321, 1'b0, 1'b0);
		// other ports and port reads
		io_write({8'h40, 8'h55}, 8'h81);
		io_read({8'h40, PAGER_PORT_DEFAULT});
		mem_cycle("other_port", 16'h7FFF, 1'b0, 1'b0);
		io_write({8'h00, CONFIG_PORT_DEFAULT}, 8'h00);
		mem_cycle("pager_restored", 16'h4321, 1'b0, 1'b0);

		// dos flag set and clear
		mem_cycle("dos_entry_fetch", 16'h3D2F, 1'b0, 1'b1);
		mem_cycle("dos_rom_read", 16'h0123, 1'b0, 1'b0);
		mem_cycle("dos_ram_read", 16'h8100, 1'b0, 1'b0);
		mem_cycle("dos_exit_fetch", 16'hC000, 1'b0, 1'b1);
		mem_cycle("dos_entry_read", 16'h3D00, 1'b0, 1'b0);

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			r = $urandom % 16;
			port = 8'($urandom);
			// keep other-port writes off the two decoded ports
			if (port == PAGER_PORT_DEFAULT || port == CONFIG_PORT_DEFAULT)
				port = port ^ 8'h01;
			case (r)
				0, 1: io_write({8'($urandom), PAGER_PORT_DEFAULT}, 8'($urandom));
				2: io_write({8'($urandom), CONFIG_PORT_DEFAULT}, 8'($urandom));
				3: io_write({8'($urandom), port}, 8'($urandom));
				4: io_read({8'($urandom), 8'($urandom)});
				5, 6, 7: mem_cycle("rand_read", 16'($urandom), 1'b0, 1'b0);
				8, 9: mem_cycle("rand_write", 16'($urandom), 1'b1, 1'b0);
				10, 11, 12: mem_cycle("rand_dos_fetch",
					{DOS_ENTRY_DEFAULT, 8'($urandom)}, 1'b0, 1'b1);
				default: mem_cycle("rand_ram_fetch",
					{2'(1 + $urandom % 3), 14'($urandom)}, 1'b0, 1'b1);
			endcase
		end

		// room for a stray mem_valid to show up
		repeat (4) bus_step();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- verilog/atm_mapper_top.sv
`timescale 1ns/100ps

module atm_mapper_top #(
	parameter logic [7:0] PAGER_PORT  = z80_bus_pkg::PAGER_PORT_DEFAULT,
	parameter logic [7:0] CONFIG_PORT = z80_bus_pkg::CONFIG_PORT_DEFAULT,
	parameter logic [7:0] DOS_ENTRY   = z80_bus_pkg::DOS_ENTRY_DEFAULT
) (
	input  logic                    fclk,
	input  logic                    rst,
	input  logic [15:0]             a,
	input  logic [7:0]              d,
	input  logic                    iorq_n,
	input  logic                    mreq_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic                    m1_n,
	output logic                    mem_valid,
	output memmap_pkg::mem_access_t mem_access,
	output logic                    dos
);

	import z80_bus_pkg::*;
	import memmap_pkg::*;

	logic        io_wr_stb;
	io_write_t   io_wr;
	logic        mem_stb;
	mem_cycle_t  mem_cyc;
	window_set_t win_map;

	////////////////////////////////////////////////////////////////////////////
	// z80 side
	////////////////////////////////////////////////////////////////////////////

	z80_bus_front u_front (
		.fclk     (fclk),
		.rst      (rst),
		.a        (a),
		.d        (d),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.io_wr_stb(io_wr_stb),
		.io_wr    (io_wr),
		.mem_stb  (mem_stb),
		.mem_cyc  (mem_cyc)
	);

	////////////////////////////////////////////////////////////////////////////
	// ATM pagers, dos flag and translation
	////////////////////////////////////////////////////////////////////////////

	window_pagers #(
		.PAGER_PORT (PAGER_PORT),
		.CONFIG_PORT(CONFIG_PORT)
	) u_pagers (
		.fclk     (fclk),
		.rst      (rst),
		.io_wr_stb(io_wr_stb),
		.io_wr    (io_wr),
		.win_map  (win_map)
	);

	dos_control #(
		.DOS_ENTRY(DOS_ENTRY)
	) u_dos (
		.fclk    (fclk),
		.rst     (rst),
		.mem_stb (mem_stb),
		.mem_cyc (mem_cyc),
		.win0_rom(win_map[0].rom),
		.dos     (dos)
	);

	mem_translate u_translate (
		.fclk      (fclk),
		.rst       (rst),
		.mem_stb   (mem_stb),
		.mem_cyc   (mem_cyc),
		.win_map   (win_map),
		.dos       (dos),
		.mem_valid (mem_valid),
		.mem_access(mem_access)
	);

endmodule

//--- verilog/mem_translate.sv
`timescale 1ns/100ps

module mem_translate (
	input  logic                    fclk,
	input  logic                    rst,
	input  logic                    mem_stb,
	input  z80_bus_pkg::mem_cycle_t mem_cyc,
	input  memmap_pkg::window_set_t win_map,
	input  logic                    dos,
	output logic                    mem_valid,
	output memmap_pkg::mem_access_t mem_access
);

	import memmap_pkg::*;

	window_map_t sel;
	mem_access_t next_access;

	// window by a[15:14]
	assign sel = win_map[mem_cyc.addr[15:14]];

	always_comb
	begin
		next_access.rom    = sel.rom;
		next_access.page   = sel.page;
		next_access.offset = mem_cyc.addr[13:0];
		next_access.wr     = mem_cyc.wr;
		// rom pages are 32 deep, bit 0 picks basic or dos
		if (sel.rom)
			next_access.page = {3'b000, sel.page[4:1], dos};
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			mem_valid <= 1'b0;
		else
			mem_valid <= mem_stb;
	end

	always_ff @(posedge fclk)
	begin
		if (mem_stb)
			mem_access <= next_access;
	end

	// rom chip only decodes 5 page bits
	assert property (@(posedge fclk) disable iff (rst)
		mem_valid && mem_access.rom |-> (mem_access.page[7:5] == 3'b000));

endmodule

//--- verilog/dos_control.sv
`timescale 1ns/100ps

module dos_control #(
	parameter logic [7:0] DOS_ENTRY = z80_bus_pkg::DOS_ENTRY_DEFAULT
) (
	input  logic                    fclk,
	input  logic                    rst,
	input  logic                    mem_stb,
	input  z80_bus_pkg::mem_cycle_t mem_cyc,
	input  logic                    win0_rom,
	output logic                    dos
);

	logic fetch;
	logic dos_on;
	logic dos_off;

	// only opcode fetches move the flag
	assign fetch = mem_stb && mem_cyc.m1;

	// entry area counts only while basic rom sits in window 0
	assign dos_on = fetch && (mem_cyc.addr[15:8] == DOS_ENTRY) && win0_rom;

	// leaving rom space
	assign dos_off = fetch && (mem_cyc.addr[15:14] != 2'b00);

	always_ff @(posedge fclk)
	begin
		if (rst)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

	// a plain read or write never turns dos on
	assert property (@(posedge fclk) disable iff (rst)
		$rose(dos) |-> $past(mem_stb && mem_cyc.m1));

endmodule

//--- verilog/window_pagers.sv
`timescale 1ns/100ps

module window_pagers #(
	parameter logic [7:0] PAGER_PORT  = z80_bus_pkg::PAGER_PORT_DEFAULT,
	parameter logic [7:0] CONFIG_PORT = z80_bus_pkg::CONFIG_PORT_DEFAULT
) (
	input  logic                     fclk,
	input  logic                     rst,
	input  logic                     io_wr_stb,
	input  z80_bus_pkg::io_write_t   io_wr,
	output memmap_pkg::window_set_t  win_map
);

	import memmap_pkg::*;

	localparam int WIN_BITS = $clog2(NUM_WINDOWS);

	window_set_t         pages;
	logic                pager_on;
	logic                pager_wr;
	logic                config_wr;
	logic [WIN_BITS-1:0] wr_win;
	window_map_t         wr_map;

	////////////////////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////////////////////

	assign pager_wr  = io_wr_stb && (io_wr.port == PAGER_PORT);
	assign config_wr = io_wr_stb && (io_wr.port == CONFIG_PORT);

	// window from a[15:14] of the out instruction
	assign wr_win = io_wr.addr_hi[7:6];

	// d7 low means rom
	assign wr_map.rom  = ~io_wr.data[7];
	assign wr_map.page = {1'b0, io_wr.data[6:0]};

	////////////////////////////////////////////////////////////////////////////
	// page registers and pager enable
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			pages    <= RESET_MAP;
			pager_on <= 1'b0;
		end
		else
		begin
			if (pager_wr)
				pages[wr_win] <= wr_map;
			if (config_wr)
				pager_on <= io_wr.data[0];
		end
	end

	// pager off keeps the fixed map, registers are still writable
	assign win_map = pager_on ? pages : RESET_MAP;

	// a page write leaves the other windows alone
	for (genvar i = 0; i < NUM_WINDOWS; i++)
	begin : g_win_check
		assert property (@(posedge fclk) disable iff (rst)
			pager_wr && (wr_win != i) |=> $stable(pages[i]));
	end

endmodule

//--- verilog/z80_bus_front.sv
`timescale 1ns/100ps

module z80_bus_front (
	input  logic                   fclk,
	input  logic                   rst,
	input  logic [15:0]            a,
	input  logic [7:0]             d,
	input  logic                   iorq_n,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   m1_n,
	output logic                   io_wr_stb,
	output z80_bus_pkg::io_write_t io_wr,
	output logic                   mem_stb,
	output z80_bus_pkg::mem_cycle_t mem_cyc
);

	import z80_bus_pkg::*;

	logic       io_wr_act;
	logic       mem_act;
	io_write_t  io_wr_raw;
	mem_cycle_t mem_raw;

	////////////////////////////////////////////////////////////////////////////
	// strobe decode
	////////////////////////////////////////////////////////////////////////////

	// port writes only, int ack has m1 low
	assign io_wr_act = ~iorq_n & ~wr_n & m1_n;

	// refresh has mreq without rd/wr and drops out here
	assign mem_act = ~mreq_n & (~rd_n | ~wr_n);

	assign io_wr_raw.addr_hi = a[15:8];
	assign io_wr_raw.port    = a[7:0];
	assign io_wr_raw.data    = d;

	assign mem_raw.addr = a;
	assign mem_raw.wr   = ~wr_n;
	assign mem_raw.m1   = ~m1_n;

	////////////////////////////////////////////////////////////////////////////
	// cycle latches
	////////////////////////////////////////////////////////////////////////////

	bus_cycle_latch #(
		.payload_t(io_write_t)
	) u_io_latch (
		.fclk      (fclk),
		.rst       (rst),
		.active    (io_wr_act),
		.payload_in(io_wr_raw),
		.stb       (io_wr_stb),
		.payload   (io_wr)
	);

	bus_cycle_latch #(
		.payload_t(mem_cycle_t)
	) u_mem_latch (
		.fclk      (fclk),
		.rst       (rst),
		.active    (mem_act),
		.payload_in(mem_raw),
		.stb       (mem_stb),
		.payload   (mem_cyc)
	);

endmodule

//--- verilog/bus_cycle_latch.sv
`timescale 1ns/100ps

module bus_cycle_latch #(
	parameter type payload_t = logic
) (
	input  logic     fclk,
	input  logic     rst,
	input  logic     active,
	input  payload_t payload_in,
	output logic     stb,
	output payload_t payload
);

	logic [1:0] act_sync;
	logic       act_prev;
	logic       act_rise;
	payload_t   pay_d1;
	payload_t   pay_d2;

	// rising edge of the synchronized level
	assign act_rise = act_sync[1] & ~act_prev;

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			act_sync <= 2'b00;
			act_prev <= 1'b0;
			stb      <= 1'b0;
		end
		else
		begin
			act_sync <= {act_sync[0], active};
			act_prev <= act_sync[1];
			stb      <= act_rise;
		end
	end

	// payload follows the same two stages as active
	always_ff @(posedge fclk)
	begin
		pay_d1 <= payload_in;
		pay_d2 <= pay_d1;
		if (act_rise)
			payload <= pay_d2;
	end

	// one pulse per bus cycle
	assert property (@(posedge fclk) disable iff (rst) stb |=> !stb);

endmodule

//--- verilog/memmap_pkg.sv
package memmap_pkg;

	////////////////////////////////////////////////////////////////////////////
	// window layout
	////////////////////////////////////////////////////////////////////////////

	// 16k windows, selected by a[15:14]
	localparam int NUM_WINDOWS = 4;

	typedef logic [7:0] page_t;

	typedef struct packed {
		logic  rom;
		page_t page;
	} window_map_t;

	// index is the window number
	typedef window_map_t [NUM_WINDOWS-1:0] window_set_t;

	////////////////////////////////////////////////////////////////////////////
	// translated access
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        rom;
		page_t       page;
		logic [13:0] offset;
		logic        wr;
	} mem_access_t;

	// plain 48k-style map, listed from window 3 down to window 0
	localparam window_set_t RESET_MAP = '{
		'{rom: 1'b0, page: 8'd0},
		'{rom: 1'b0, page: 8'd2},
		'{rom: 1'b0, page: 8'd5},
		'{rom: 1'b1, page: 8'd0}
	};

endpackage

//--- verilog/z80_bus_pkg.sv
package z80_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus cycle payloads
	////////////////////////////////////////////////////////////////////////////

	// one out (port) write, port number on the low address byte
	typedef struct packed {
		logic [7:0] addr_hi;
		logic [7:0] port;
		logic [7:0] data;
	} io_write_t;

	// one memory read or write, m1 marks an opcode fetch
	typedef struct packed {
		logic [15:0] addr;
		logic        wr;
		logic        m1;
	} mem_cycle_t;

	////////////////////////////////////////////////////////////////////////////
	// port and address defaults
	////////////////////////////////////////////////////////////////////////////

	// ATM page registers, xxF7
	localparam logic [7:0] PAGER_PORT_DEFAULT  = 8'hF7;
	// ATM config, xx77
	localparam logic [7:0] CONFIG_PORT_DEFAULT = 8'h77;
	// TR-DOS entry points live at 3Dxx
	localparam logic [7:0] DOS_ENTRY_DEFAULT   = 8'h3D;

endpackage
